//--- design/load_channel.sv
/*
 * Load channel: strided reads from TCDM, responses buffered
 * and delivered in order on the X stream
 */

`default_nettype none

module load_channel (
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,
  input  wire logic                         clear_i,
  input  wire streamer_pkg::stream_ctrl_t   ctrl_i,
  output streamer_pkg::tcdm_req_t           req_o,
  input  wire streamer_pkg::tcdm_rsp_t      rsp_i,
  output logic                              x_valid_o,
  output logic [streamer_pkg::DATA_W-1:0]   x_data_o,
  input  wire logic                         x_ready_i,
  output logic                              done_o
);

  streamer_pkg::chan_state_e state_q, state_d;
  streamer_pkg::len_t        x_left_q;
  streamer_pkg::addr_t       rd_addr;
  logic gen_busy, fifo_space, fifo_empty;
  logic rd_req, rd_gnt, push, pop;

  stride_addr_gen i_addr_gen (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .clear_i ( clear_i  ),
    .ctrl_i  ( ctrl_i   ),
    .step_i  ( rd_gnt   ),
    .addr_o  ( rd_addr  ),
    .busy_o  ( gen_busy ),
    .last_o  (          )
  );

  // Issue a read only if its response will find a free slot
  assign rd_req = gen_busy & fifo_space;
  assign rd_gnt = rd_req & rsp_i.gnt;

  assign req_o.req  = rd_req;
  assign req_o.wen  = 1'b1;
  assign req_o.add  = rd_addr;
  assign req_o.data = '0;
  assign req_o.be   = '1;

  // Responses of a job aborted by clear are dropped
  assign push = rsp_i.r_valid & (state_q == streamer_pkg::CHAN_BUSY);
  assign pop  = x_valid_o & x_ready_i;

  load_resp_fifo i_resp_fifo (
    .clk_i       ( clk_i        ),
    .rst_n_i     ( rst_n_i      ),
    .clear_i     ( clear_i      ),
    .reserve_i   ( rd_gnt       ),
    .push_i      ( push         ),
    .pop_i       ( pop          ),
    .push_data_i ( rsp_i.r_data ),
    .space_o     ( fifo_space   ),
    .empty_o     ( fifo_empty   ),
    .pop_data_o  ( x_data_o     )
  );

  assign x_valid_o = !fifo_empty;

  always_comb begin
    state_d = state_q;
    if (ctrl_i.start) begin
      state_d = (ctrl_i.length == '0) ? streamer_pkg::CHAN_DONE : streamer_pkg::CHAN_BUSY;
    end else if (state_q == streamer_pkg::CHAN_BUSY && pop &&
                 x_left_q == streamer_pkg::len_t'(1)) begin
      state_d = streamer_pkg::CHAN_DONE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= streamer_pkg::CHAN_IDLE;
      x_left_q <= '0;
    end else if (clear_i) begin
      state_q  <= streamer_pkg::CHAN_IDLE;
      x_left_q <= '0;
    end else begin
      state_q <= state_d;
      if (ctrl_i.start) begin
        x_left_q <= ctrl_i.length;
      end else if (pop) begin
        x_left_q <= x_left_q - streamer_pkg::len_t'(1);
      end
    end
  end

  assign done_o = (state_q == streamer_pkg::CHAN_DONE);

endmodule

`default_nettype wire

//--- design/load_resp_fifo.sv
/*
 * Load response FIFO with slot reservation for reads in flight
 */

`default_nettype none

module load_resp_fifo (
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,
  input  wire logic                         clear_i,
  input  wire logic                         reserve_i,
  input  wire logic                         push_i,
  input  wire logic                         pop_i,
  input  wire logic [streamer_pkg::DATA_W-1:0] push_data_i,
  output logic                              space_o,
  output logic                              empty_o,
  output logic [streamer_pkg::DATA_W-1:0]   pop_data_o
);

  streamer_pkg::data_t     mem_q [streamer_pkg::LOAD_FIFO_DEPTH];
  streamer_pkg::fifo_ptr_t wr_ptr_q, rd_ptr_q;
  streamer_pkg::fifo_cnt_t data_cnt_q, resv_cnt_q;
  streamer_pkg::fifo_cnt_t used_cnt;

  // Slots taken by stored words plus reads still on their way back
  assign used_cnt = data_cnt_q + resv_cnt_q;
  assign space_o  = used_cnt < streamer_pkg::fifo_cnt_t'(streamer_pkg::LOAD_FIFO_DEPTH);
  assign empty_o  = (data_cnt_q == '0);

  assign pop_data_o = mem_q[rd_ptr_q];

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      data_cnt_q <= '0;
      resv_cnt_q <= '0;
    end else if (clear_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      data_cnt_q <= '0;
      resv_cnt_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + streamer_pkg::fifo_ptr_t'(1);
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + streamer_pkg::fifo_ptr_t'(1);
      end
      resv_cnt_q <= resv_cnt_q + streamer_pkg::fifo_cnt_t'(reserve_i)
                    - streamer_pkg::fifo_cnt_t'(push_i);
      data_cnt_q <= data_cnt_q + streamer_pkg::fifo_cnt_t'(push_i)
                    - streamer_pkg::fifo_cnt_t'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Every returning word was granted a slot earlier
  a_push_reserved : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) push_i |-> (resv_cnt_q != '0)
  );

  a_pop_not_empty : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o
  );

endmodule

`default_nettype wire

//--- design/redmule_streamer_lite.sv
/*
 * Streamer top level: load channel, store channel and
 * the arbiter onto the single TCDM port
 */

`default_nettype none

module redmule_streamer_lite (
  input  wire logic                            clk_i,
  input  wire logic                            rst_n_i,
  input  wire logic                            clear_i,
  input  wire streamer_pkg::streamer_ctrl_t    ctrl_i,
  output streamer_pkg::streamer_flags_t        flags_o,
  output streamer_pkg::tcdm_req_t              tcdm_req_o,
  input  wire streamer_pkg::tcdm_rsp_t         tcdm_rsp_i,
  output logic                                 x_valid_o,
  output logic [streamer_pkg::DATA_W-1:0]      x_data_o,
  input  wire logic                            x_ready_i,
  input  wire logic                            z_valid_i,
  input  wire logic [streamer_pkg::DATA_W-1:0] z_data_i,
  output logic                                 z_ready_o
);

  streamer_pkg::tcdm_req_t load_req, store_req;
  streamer_pkg::tcdm_rsp_t load_rsp, store_rsp;

  load_channel i_load_channel (
    .clk_i     ( clk_i             ),
    .rst_n_i   ( rst_n_i           ),
    .clear_i   ( clear_i           ),
    .ctrl_i    ( ctrl_i.load       ),
    .req_o     ( load_req          ),
    .rsp_i     ( load_rsp          ),
    .x_valid_o ( x_valid_o         ),
    .x_data_o  ( x_data_o          ),
    .x_ready_i ( x_ready_i         ),
    .done_o    ( flags_o.load_done )
  );

  store_channel i_store_channel (
    .clk_i     ( clk_i              ),
    .rst_n_i   ( rst_n_i            ),
    .clear_i   ( clear_i            ),
    .ctrl_i    ( ctrl_i.store       ),
    .req_o     ( store_req          ),
    .rsp_i     ( store_rsp          ),
    .z_valid_i ( z_valid_i          ),
    .z_data_i  ( z_data_i           ),
    .z_ready_o ( z_ready_o          ),
    .done_o    ( flags_o.store_done )
  );

  tcdm_port_arbiter i_port_arbiter (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .load_req_i  ( load_req   ),
    .store_req_i ( store_req  ),
    .load_rsp_o  ( load_rsp   ),
    .store_rsp_o ( store_rsp  ),
    .mem_req_o   ( tcdm_req_o ),
    .mem_rsp_i   ( tcdm_rsp_i )
  );

endmodule

`default_nettype wire

//--- design/store_channel.sv
/*
 * Store channel: one Z word held at a time and written
 * to the next strided TCDM address
 */

`default_nettype none

module store_channel (
  input  wire logic                            clk_i,
  input  wire logic                            rst_n_i,
  input  wire logic                            clear_i,
  input  wire streamer_pkg::stream_ctrl_t      ctrl_i,
  output streamer_pkg::tcdm_req_t              req_o,
  input  wire streamer_pkg::tcdm_rsp_t         rsp_i,
  input  wire logic                            z_valid_i,
  input  wire logic [streamer_pkg::DATA_W-1:0] z_data_i,
  output logic                                 z_ready_o,
  output logic                                 done_o
);

  streamer_pkg::chan_state_e state_q, state_d;
  streamer_pkg::data_t       z_data_q;
  streamer_pkg::addr_t       wr_addr;
  logic full_q;
  logic gen_busy, gen_last;
  logic z_take, wr_gnt;

  stride_addr_gen i_addr_gen (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .clear_i ( clear_i  ),
    .ctrl_i  ( ctrl_i   ),
    .step_i  ( wr_gnt   ),
    .addr_o  ( wr_addr  ),
    .busy_o  ( gen_busy ),
    .last_o  ( gen_last )
  );

  // A new word only once the previous write has gone out
  assign z_ready_o = gen_busy & !full_q;
  assign z_take    = z_valid_i & z_ready_o;
  assign wr_gnt    = full_q & rsp_i.gnt;

  assign req_o.req  = full_q;
  assign req_o.wen  = 1'b0;
  assign req_o.add  = wr_addr;
  assign req_o.data = z_data_q;
  assign req_o.be   = '1;

  always_ff @(posedge clk_i) begin
    if (z_take) begin
      z_data_q <= z_data_i;
    end
  end

  always_comb begin
    state_d = state_q;
    if (ctrl_i.start) begin
      state_d = (ctrl_i.length == '0) ? streamer_pkg::CHAN_DONE : streamer_pkg::CHAN_BUSY;
    end else if (wr_gnt && gen_last) begin
      state_d = streamer_pkg::CHAN_DONE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= streamer_pkg::CHAN_IDLE;
      full_q  <= 1'b0;
    end else if (clear_i) begin
      state_q <= streamer_pkg::CHAN_IDLE;
      full_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (z_take) begin
        full_q <= 1'b1;
      end else if (wr_gnt) begin
        full_q <= 1'b0;
      end
    end
  end

  assign done_o = (state_q == streamer_pkg::CHAN_DONE);

endmodule

`default_nettype wire

//--- design/streamer_pkg.sv
/*
 * Shared definitions of the streamer: word, address and length widths,
 * load FIFO sizing, TCDM request and response structs, channel job and
 * status structs, and the channel state enum
 */

`default_nettype none

package streamer_pkg;

  localparam int unsigned DATA_W          = 32;
  localparam int unsigned ADDR_W          = 16;
  localparam int unsigned LEN_W           = 12;
  localparam int unsigned BE_W            = DATA_W / 8;
  localparam int unsigned LOAD_FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PTR_W      = $clog2(LOAD_FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_W      = FIFO_PTR_W + 1;

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [LEN_W-1:0]      len_t;
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

  // Memory port, request side (wen high means read)
  typedef struct packed {
    logic              req;
    logic              wen;
    addr_t             add;
    data_t             data;
    logic [BE_W-1:0]   be;
  } tcdm_req_t;

  // Memory port, response side
  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    data_t r_data;
  } tcdm_rsp_t;

  // Job of one channel, start is a single-cycle pulse
  typedef struct packed {
    logic  start;
    addr_t base_addr;
    len_t  stride;
    len_t  length;
  } stream_ctrl_t;

  typedef struct packed {
    stream_ctrl_t load;
    stream_ctrl_t store;
  } streamer_ctrl_t;

  typedef struct packed {
    logic load_done;
    logic store_done;
  } streamer_flags_t;

  typedef enum logic [1:0] {
    CHAN_IDLE,
    CHAN_BUSY,
    CHAN_DONE
  } chan_state_e;

endpackage

`default_nettype wire

//--- design/stride_addr_gen.sv
/*
 * Strided word address generator with remaining beat count
 */

`default_nettype none

module stride_addr_gen (
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,
  input  wire logic                         clear_i,
  input  wire streamer_pkg::stream_ctrl_t   ctrl_i,
  input  wire logic                         step_i,
  output logic [streamer_pkg::ADDR_W-1:0]   addr_o,
  output logic                              busy_o,
  output logic                              last_o
);

  streamer_pkg::addr_t addr_q;
  streamer_pkg::addr_t stride_q;
  streamer_pkg::len_t  left_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_q <= '0;
      left_q <= '0;
    end else if (clear_i) begin
      left_q <= '0;
    end else if (ctrl_i.start) begin
      addr_q <= ctrl_i.base_addr;
      left_q <= ctrl_i.length;
    end else if (step_i) begin
      addr_q <= addr_q + stride_q;
      left_q <= left_q - streamer_pkg::len_t'(1);
    end
  end

  // Stride is captured with the job
  always_ff @(posedge clk_i) begin
    if (ctrl_i.start) begin
      stride_q <= streamer_pkg::addr_t'(ctrl_i.stride);
    end
  end

  assign addr_o = addr_q;
  assign busy_o = (left_q != '0);
  assign last_o = (left_q == streamer_pkg::len_t'(1));

  // The owning channel only steps on a granted transfer of a live job
  a_step_when_busy : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) step_i |-> busy_o
  );

endmodule

`default_nettype wire

//--- design/tcdm_port_arbiter.sv
/*
 * Fixed-priority TCDM port arbiter, store over load,
 * with read responses returned to the load side
 */

`default_nettype none

module tcdm_port_arbiter (
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  input  wire streamer_pkg::tcdm_req_t  load_req_i,
  input  wire streamer_pkg::tcdm_req_t  store_req_i,
  output streamer_pkg::tcdm_rsp_t       load_rsp_o,
  output streamer_pkg::tcdm_rsp_t       store_rsp_o,
  output streamer_pkg::tcdm_req_t       mem_req_o,
  input  wire streamer_pkg::tcdm_rsp_t  mem_rsp_i
);

  logic sel_store;
  logic rd_gnt;

  // Store side always wins the port
  assign sel_store = store_req_i.req;
  assign mem_req_o = sel_store ? store_req_i : load_req_i;

  assign store_rsp_o.gnt     = sel_store & mem_rsp_i.gnt;
  assign store_rsp_o.r_valid = 1'b0;
  assign store_rsp_o.r_data  = '0;

  assign load_rsp_o.gnt     = !sel_store & mem_rsp_i.gnt;
  assign load_rsp_o.r_valid = mem_rsp_i.r_valid;
  assign load_rsp_o.r_data  = mem_rsp_i.r_data;

  // Read transfer on the memory side
  assign rd_gnt = mem_req_o.req & mem_req_o.wen & mem_rsp_i.gnt;

  // Read data follows a granted read by one cycle and writes give no response
  a_rvalid_after_read : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) mem_rsp_i.r_valid == $past(rd_gnt)
  );

endmodule

`default_nettype wire

//--- filelist.f
design/streamer_pkg.sv
design/stride_addr_gen.sv
design/load_resp_fifo.sv
design/load_channel.sv
design/store_channel.sv
design/tcdm_port_arbiter.sv
design/redmule_streamer_lite.sv
tests/tb_tcdm_memory.sv
tests/tb_streamer.sv

//--- tests/streamer_stim.txt
# P addr word : preload one memory word, all fields hex
# T kind ld_base ld_stride ld_len st_base st_stride st_len x_stall : one test (load store both clear)
# D word : next Z stream word, taken in order by the store tests
P 0100 11110000
P 0101 22220001
P 0102 33330002
P 0103 44440003
P 0200 a0a00200
P 0203 b0b00203
P 0206 c0c00206
T load  0100 1 8 0000 0 0 0
T load  0200 3 6 0000 0 0 0
T store 0000 0 0 0400 1 4 0
T store 0000 0 0 0500 4 3 0
T load  0100 2 a 0000 0 0 1
T both  0200 1 9 0600 2 4 1
T clear 0100 1 c 0000 0 0 0
T load  0400 1 4 0000 0 0 1
D deadbeef
D 01234567
D 89abcdef
D 5a5a0003
D 00c0ffee
D 12345678
D 87654321
D f00d0001
D f00d0002
D f00d0003
D f00d0004

//--- tests/tb_streamer.sv
/*
 * Streamer testbench with clock and reset, stim file parsing, load, store,
 * concurrent and clear tests, X data and memory checks
 */

`default_nettype none

module tb_streamer;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYC = 4000;
  localparam int WORDS       = 1 << streamer_pkg::ADDR_W;

  logic clk, rst_n, clear, x_valid, x_ready, z_valid, z_ready;
  streamer_pkg::streamer_ctrl_t  ctrl;
  streamer_pkg::streamer_flags_t flags;
  streamer_pkg::tcdm_req_t       tcdm_req;
  streamer_pkg::tcdm_rsp_t       tcdm_rsp;
  streamer_pkg::data_t           x_data, z_data;

  streamer_pkg::data_t exp_mem [WORDS];
  streamer_pkg::data_t store_words [$];
  streamer_pkg::data_t x_got [$];
  string  test_lines [$];
  int     err_cnt, tests_ok, tests_run, store_next;
  integer seed;

  redmule_streamer_lite dut (
    .clk_i      ( clk      ),
    .rst_n_i    ( rst_n    ),
    .clear_i    ( clear    ),
    .ctrl_i     ( ctrl     ),
    .flags_o    ( flags    ),
    .tcdm_req_o ( tcdm_req ),
    .tcdm_rsp_i ( tcdm_rsp ),
    .x_valid_o  ( x_valid  ),
    .x_data_o   ( x_data   ),
    .x_ready_i  ( x_ready  ),
    .z_valid_i  ( z_valid  ),
    .z_data_i   ( z_data   ),
    .z_ready_o  ( z_ready  )
  );

  tb_tcdm_memory mem_model (
    .clk_i   ( clk      ),
    .rst_n_i ( rst_n    ),
    .req_i   ( tcdm_req ),
    .rsp_o   ( tcdm_rsp )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic streamer_pkg::addr_t beat_addr(input streamer_pkg::addr_t base,
                                                    input streamer_pkg::len_t stride,
                                                    input int k);
    return base + streamer_pkg::addr_t'(stride) * streamer_pkg::addr_t'(k);
  endfunction

  // Preload lines go straight into the model while tests and Z words are queued
  task automatic read_stim(output bit opened);
    int fd;
    string line, tag;
    streamer_pkg::addr_t a;
    streamer_pkg::data_t w;
    fd = $fopen("tests/streamer_stim.txt", "r");
    opened = (fd != 0);
    while (opened && !$feof(fd)) begin
      if ($fgets(line, fd) > 0 && line.getc(0) != "#" && $sscanf(line, "%s", tag) == 1) begin
        if (tag == "P") begin
          void'($sscanf(line, "%s %h %h", tag, a, w));
          mem_model.mem[a] = w;
        end else if (tag == "T") begin
          test_lines.push_back(line);
        end else if (tag == "D") begin
          void'($sscanf(line, "%s %h", tag, w));
          store_words.push_back(w);
        end
      end
    end
    for (int i = 0; i < WORDS; i++) begin
      exp_mem[i] = mem_model.mem[i];
    end
  endtask

  task automatic expect_low(input string name, input logic val);
    assert (val === 1'b0) else begin
      $display("mismatch %s: got %h expected 0", name, val);
      err_cnt++;
    end
  endtask

  task automatic check_memory();
    int bad;
    bad = 0;
    for (int i = 0; i < WORDS; i++) begin
      assert (mem_model.mem[i] === exp_mem[i]) else begin
        if (bad == 0) begin
          $display("mismatch mem[%h]: got %h expected %h", 16'(i), mem_model.mem[i], exp_mem[i]);
        end
        bad++;
      end
    end
    if (bad != 0) begin
      err_cnt++;
    end
  endtask

  task automatic check_x_beats(input streamer_pkg::addr_t base, input streamer_pkg::len_t stride,
                               input int count);
    for (int k = 0; k < count && k < x_got.size(); k++) begin
      assert (x_got[k] === exp_mem[beat_addr(base, stride, k)]) else begin
        $display("mismatch x_data_o beat %0d: got %h expected %h", k, x_got[k],
                 exp_mem[beat_addr(base, stride, k)]);
        err_cnt++;
      end
    end
  endtask

  task automatic collect_x_beats(input streamer_pkg::addr_t base, input streamer_pkg::len_t stride,
                                 input int len, input bit stall);
    int cyc;
    bit finished;
    cyc = 0;
    finished = 1'b0;
    x_got.delete();
    while (!finished && cyc < TIMEOUT_CYC) begin
      @(negedge clk);
      if (x_valid && x_ready) begin
        x_got.push_back(x_data);
      end
      if (flags.load_done) begin
        finished = 1'b1;
      end else begin
        @(posedge clk);
        #2;
        x_ready = stall ? (($random(seed) & 3) == 0) : 1'b1;
        cyc++;
      end
    end
    assert (finished) else begin
      $display("timeout while waiting for load_done");
      err_cnt++;
    end
    assert (x_got.size() == len) else begin
      $display("mismatch x beat count: got %h expected %h", x_got.size(), len);
      err_cnt++;
    end
    expect_low("x_valid_o", x_valid);
    check_x_beats(base, stride, len);
  endtask

  task automatic send_z_words(input streamer_pkg::addr_t base, input streamer_pkg::len_t stride,
                              input int len);
    int cyc, idx;
    bit fire, finished;
    assert (store_next + len <= store_words.size()) else begin
      $display("stimulus file holds too few store words");
      err_cnt++;
    end
    for (int k = 0; k < len; k++) begin
      exp_mem[beat_addr(base, stride, k)] = store_words[store_next + k];
    end
    cyc = 0;
    idx = 0;
    finished = 1'b0;
    z_valid = (len > 0);
    z_data = store_words[store_next];
    while (!finished && cyc < TIMEOUT_CYC) begin
      @(negedge clk);
      fire = z_valid && z_ready;
      if (fire) begin
        idx++;
      end
      if (flags.store_done) begin
        finished = 1'b1;
      end else begin
        @(posedge clk);
        #2;
        z_valid = (idx < len);
        z_data = (idx < len) ? store_words[store_next + idx] : '0;
        cyc++;
      end
    end
    assert (finished && idx == len) else begin
      $display("store did not finish: %0d of %0d Z words taken", idx, len);
      err_cnt++;
    end
    store_next += len;
  endtask

  // Load aborted by clear after two X beats
  task automatic run_clear_test(input streamer_pkg::addr_t base, input streamer_pkg::len_t stride);
    int cyc;
    cyc = 0;
    x_got.delete();
    x_ready = 1'b1;
    while (x_got.size() < 2 && cyc < TIMEOUT_CYC) begin
      @(negedge clk);
      if (x_valid && x_ready) begin
        x_got.push_back(x_data);
      end
      @(posedge clk);
      #2;
      cyc++;
    end
    assert (x_got.size() >= 2) else begin
      $display("timeout while waiting for X beats before clear");
      err_cnt++;
    end
    x_ready = 1'b0;
    clear = 1'b1;
    @(posedge clk);
    #2;
    clear = 1'b0;
    repeat (3) @(negedge clk);
    expect_low("load_done", flags.load_done);
    expect_low("store_done", flags.store_done);
    expect_low("x_valid_o", x_valid);
    check_x_beats(base, stride, 2);
  endtask

  task automatic run_test(input string line);
    string tag, kind;
    streamer_pkg::addr_t lb, sb;
    streamer_pkg::len_t  ls, ll, ss, sl;
    int  stall, err_before;
    bit  do_load, do_store;
    err_before = err_cnt;
    void'($sscanf(line, "%s %s %h %h %h %h %h %h %h", tag, kind, lb, ls, ll, sb, ss, sl, stall));
    do_load = (kind == "load" || kind == "both" || kind == "clear");
    do_store = (kind == "store" || kind == "both");
    @(posedge clk);
    #2;
    ctrl = '0;
    ctrl.load.start      = do_load;
    ctrl.load.base_addr  = lb;
    ctrl.load.stride     = ls;
    ctrl.load.length     = ll;
    ctrl.store.start     = do_store;
    ctrl.store.base_addr = sb;
    ctrl.store.stride    = ss;
    ctrl.store.length    = sl;
    x_ready = do_load;
    @(posedge clk);
    #2;
    ctrl.load.start = 1'b0;
    ctrl.store.start = 1'b0;
    if (kind == "clear") begin
      run_clear_test(lb, ls);
    end else begin
      fork
        if (do_load) collect_x_beats(lb, ls, int'(ll), stall != 0);
        if (do_store) send_z_words(sb, ss, int'(sl));
      join
    end
    @(posedge clk);
    #2;
    x_ready = 1'b0;
    z_valid = 1'b0;
    check_memory();
    tests_run++;
    if (err_cnt == err_before) begin
      tests_ok++;
      $display("test %0d %s: pass", tests_run, kind);
    end else begin
      $display("test %0d %s: fail", tests_run, kind);
    end
  endtask

  initial begin
    bit opened;
    rst_n = 1'b0;
    clear = 1'b0;
    ctrl = '0;
    x_ready = 1'b0;
    z_valid = 1'b0;
    z_data = '0;
    err_cnt = 0;
    tests_ok = 0;
    tests_run = 1;
    store_next = 0;
    seed = 60;
    // Preload after the model has written its fill pattern
    #1;
    read_stim(opened);
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    expect_low("x_valid_o", x_valid);
    expect_low("z_ready_o", z_ready);
    expect_low("tcdm req", tcdm_req.req);
    expect_low("load_done", flags.load_done);
    expect_low("store_done", flags.store_done);
    tests_ok = (err_cnt == 0);
    $display("test 1 reset: %s", (err_cnt == 0) ? "pass" : "fail");
    assert (opened) else begin
      $display("could not open tests/streamer_stim.txt");
      err_cnt++;
    end
    foreach (test_lines[i]) begin
      run_test(test_lines[i]);
    end
    $display("%0d of %0d tests ok, %0d errors", tests_ok, tests_run, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_tcdm_memory.sv
/*
 * TCDM memory model for the streamer testbench with an address-derived
 * fill, byte-enabled writes, random grant stalls and one-cycle read latency
 */

`default_nettype none

module tb_tcdm_memory (
  input  wire logic                        clk_i,
  input  wire logic                        rst_n_i,
  input  wire streamer_pkg::tcdm_req_t     req_i,
  output streamer_pkg::tcdm_rsp_t          rsp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WORDS = 1 << streamer_pkg::ADDR_W;

  streamer_pkg::data_t mem [WORDS];
  streamer_pkg::data_t r_data_q;
  logic   allow_q;
  logic   r_valid_q;
  integer seed;

  // Address in the low half and a scrambled copy in the high half
  initial begin
    seed = 60;
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = {16'(i) ^ 16'hc3a5, 16'(i)};
    end
  end

  // Only enabled byte lanes of a write reach the array
  function automatic streamer_pkg::data_t merge_bytes(
    input streamer_pkg::data_t               old_w,
    input streamer_pkg::data_t               new_w,
    input logic [streamer_pkg::BE_W-1:0]     be
  );
    streamer_pkg::data_t w;
    w = old_w;
    for (int b = 0; b < streamer_pkg::BE_W; b++) begin
      if (be[b]) begin
        w[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return w;
  endfunction

  assign rsp_o.gnt     = req_i.req & allow_q;
  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_data  = r_data_q;

  // Grant allowed in about half of the cycles
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      allow_q   <= 1'b0;
      r_valid_q <= 1'b0;
      r_data_q  <= '0;
    end else begin
      allow_q   <= (($random(seed) & 1) != 0);
      r_valid_q <= rsp_o.gnt & req_i.wen;
      if (rsp_o.gnt && req_i.wen) begin
        r_data_q <= mem[req_i.add];
      end
      if (rsp_o.gnt && !req_i.wen) begin
        mem[req_i.add] <= merge_bytes(mem[req_i.add], req_i.data, req_i.be);
      end
    end
  end

endmodule

`default_nettype wire
